// ==== logic/wbBusPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic word and address types for the I/O register bus
// Word address only, no byte selects
//////////////////////////////////////////////////////////////////////
package wbBusPkg;

   // Bus widths
   localparam int wbDatW = 16;            // One minicomputer word
   localparam int wbAdrW = 2;             // Four register slots

   // Data word on both read and write paths
   typedef logic [wbDatW-1:0] wbDat_t;

   // Register slot address
   typedef logic [wbAdrW-1:0] wbAdr_t;

   // Bus owner as held by the arbiter
   // CPU encodes as 0 so a cleared grant points at it
   typedef enum logic {
      cpuMaster   = 1'b0,                 // Microcode port, high priority
      panelMaster = 1'b1                  // Maintenance panel
   } masterId_t;

endpackage

// ==== logic/ioRegPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Register map and bit layout of the IOC, INR and ALD registers
// Slot 3 is unmapped and answered by the bus fabric
//////////////////////////////////////////////////////////////////////
package ioRegPkg;

   // Register slots
   localparam wbBusPkg::wbAdr_t adrIoc = 2'd0;   // Control, read/write
   localparam wbBusPkg::wbAdr_t adrInr = 2'd1;   // Input byte, read-only
   localparam wbBusPkg::wbAdr_t adrAld = 2'd2;   // Board ident, read-only

   // IOC byte
   localparam int iocW        = 8;
   localparam int iocConsole  = 0;      // Console request
   localparam int iocEmcl     = 1;      // Emergency clear, red LED
   localparam int iocLedGreen = 2;
   localparam int iocInt13A   = 3;      // Both 13 bits needed
   localparam int iocInt10En  = 4;      // Gated by tbmt
   localparam int iocInt12A   = 5;      // Both 12 bits plus dataAvail
   localparam int iocInt12B   = 6;
   localparam int iocInt13B   = 7;

   // INR byte
   localparam int inrW = 8;

   // ALD word fields, lsb and width
   localparam int aldPrintLsb = 13;
   localparam int aldPrintW   = 3;      // Board print number
   localparam int aldStrapLsb = 8;
   localparam int aldStrapW   = 5;      // ECO straps
   localparam int aldCxBit    = 7;      // Live CX status
   localparam int aldFixLsb   = 4;
   localparam int aldFixW     = 3;
   localparam logic [aldFixW-1:0] aldFixed = 3'b011;  // Bit 6 low, 5..4 high
   localparam int aldSwLsb    = 0;
   localparam int aldSwW      = 4;      // Boot switch

endpackage

// ==== logic/wbIf.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Wishbone classic link with split read and write data
// No err, rty or sel lines
//////////////////////////////////////////////////////////////////////
interface wbIf;
   import wbBusPkg::*;

   logic   cyc;       // Bus cycle in progress
   logic   stb;       // Valid transfer
   logic   we;        // 1 = write
   wbAdr_t adr;       // Register slot
   wbDat_t datW;      // Master to slave
   wbDat_t datR;      // Slave to master, valid with ack
   logic   ack;       // Single cycle pulse

   // Requesting side
   modport master (
      output cyc, stb, we, adr, datW,
      input  datR, ack
   );

   // Responding side
   modport slave (
      input  cyc, stb, we, adr, datW,
      output datR, ack
   );

endinterface

// ==== logic/ioBusFabric.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Fixed priority arbiter for two masters, CPU wins ties
// Grant held until owner drops cyc, then one idle cycle
//////////////////////////////////////////////////////////////////////
module ioBusFabric (
   input  logic clk,
   input  logic rstN,
   wbIf.slave   cpuBus,     // Microcode master
   wbIf.slave   panelBus,   // Maintenance panel master
   wbIf.master  ctrlBus,    // IOC slave
   wbIf.master  identBus    // INR and ALD slave
);
   import wbBusPkg::*;
   import ioRegPkg::*;

   masterId_t grant;        // Current owner
   logic      busy;         // Grant valid
   logic      ownCyc;
   logic      ownStb;
   logic      ownWe;
   wbAdr_t    ownAdr;
   wbDat_t    ownDatW;
   logic      reqStb;       // Owner strobe, held off during ack
   logic      ctrlSel;
   logic      identSel;
   logic      nullSel;      // Slot 3
   logic      nullAck;
   logic      slvAck;
   wbDat_t    slvDatR;
   logic      cpuOwn;
   logic      panelOwn;

   // Grant register
   always_ff @(posedge clk) begin
      if (!rstN) begin
         busy  <= 1'b0;
         grant <= cpuMaster;
      end else if (!busy) begin
         if (cpuBus.cyc) begin           // CPU first
            busy  <= 1'b1;
            grant <= cpuMaster;
         end else if (panelBus.cyc) begin
            busy  <= 1'b1;
            grant <= panelMaster;
         end
      end else if (!ownCyc) begin
         busy <= 1'b0;                   // Idle cycle follows
      end
   end

   // Owner request mux
   always_comb begin
      if (grant == panelMaster) begin
         ownCyc  = panelBus.cyc;
         ownStb  = panelBus.stb;
         ownWe   = panelBus.we;
         ownAdr  = panelBus.adr;
         ownDatW = panelBus.datW;
      end else begin
         ownCyc  = cpuBus.cyc;
         ownStb  = cpuBus.stb;
         ownWe   = cpuBus.we;
         ownAdr  = cpuBus.adr;
         ownDatW = cpuBus.datW;
      end
   end

   // Address decode
   assign ctrlSel  = (ownAdr == adrIoc);
   assign identSel = (ownAdr == adrInr) || (ownAdr == adrAld);
   assign nullSel  = !ctrlSel && !identSel;

   // No new strobe in the ack cycle, keeps acks one cycle apart
   assign reqStb = busy & ownCyc & ownStb & ~slvAck;

   assign ctrlBus.cyc   = busy & ownCyc & ctrlSel;
   assign ctrlBus.stb   = reqStb & ctrlSel;
   assign ctrlBus.we    = ownWe;
   assign ctrlBus.adr   = ownAdr;
   assign ctrlBus.datW  = ownDatW;
   assign identBus.cyc  = busy & ownCyc & identSel;
   assign identBus.stb  = reqStb & identSel;
   assign identBus.we   = ownWe;
   assign identBus.adr  = ownAdr;
   assign identBus.datW = ownDatW;

   // Unmapped slot answers itself, write dropped
   always_ff @(posedge clk) begin
      if (!rstN) nullAck <= 1'b0;
      else       nullAck <= reqStb & nullSel;
   end

   // Return path
   assign slvAck  = ctrlBus.ack | identBus.ack | nullAck;
   assign slvDatR = ctrlSel ? ctrlBus.datR : (identSel ? identBus.datR : '0);
   assign cpuOwn   = busy && (grant == cpuMaster);
   assign panelOwn = busy && (grant == panelMaster);

   assign cpuBus.ack    = cpuOwn & slvAck;      // Waiting master sees nothing
   assign cpuBus.datR   = cpuOwn ? slvDatR : '0;
   assign panelBus.ack  = panelOwn & slvAck;
   assign panelBus.datR = panelOwn ? slvDatR : '0;

endmodule

// ==== logic/ioControlReg.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// IOC control register, low byte only, high byte reads zero
// Outputs combinational from IOC and live status inputs
//////////////////////////////////////////////////////////////////////
module ioControlReg (
   input  logic clk,
   input  logic rstN,
   wbIf.slave   bus,
   input  logic tbmt,        // UART transmit buffer empty
   input  logic dataAvail,   // UART receive data available
   output logic int10,
   output logic int12,
   output logic int13,
   output logic emcl,        // Also the red LED
   output logic ledGreen,
   output logic console
);
   import wbBusPkg::*;
   import ioRegPkg::*;

   logic [iocW-1:0] ioc;
   logic            access;  // New transfer this cycle

   // One access per strobe, never in the ack cycle
   assign access = bus.cyc & bus.stb & ~bus.ack;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         bus.ack <= 1'b0;
         ioc     <= '0;
      end else begin
         bus.ack <= access;
         if (access && bus.we) begin
            ioc <= bus.datW[iocW-1:0];   // Lands with ack
         end
      end
   end

   // Readback, zero extended
   assign bus.datR = wbDat_t'(ioc);

   // Direct drives
   assign console  = ioc[iocConsole];
   assign emcl     = ioc[iocEmcl];
   assign ledGreen = ioc[iocLedGreen];

   // Interrupt gating
   assign int10 = ioc[iocInt10En] & tbmt;
   assign int12 = ioc[iocInt12A] & ioc[iocInt12B] & dataAvail;
   assign int13 = ioc[iocInt13A] & ioc[iocInt13B];

endmodule

// ==== logic/identRegs.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Read-only INR and ALD registers, writes acked and dropped
// Inputs sampled at the strobe edge, snapshot held with ack
//////////////////////////////////////////////////////////////////////
module identRegs #(
   parameter logic [ioRegPkg::aldPrintW-1:0] printNo   = 3'd5,
   parameter logic [ioRegPkg::aldStrapW-1:0] strapBits = 5'd0,
   parameter logic [ioRegPkg::aldSwW-1:0]    aldSwitch = 4'hF
) (
   input  logic                     clk,
   input  logic                     rstN,
   wbIf.slave                       bus,
   input  logic [ioRegPkg::inrW-1:0] inr,   // External input byte
   input  logic                     cx      // CX status
);
   import wbBusPkg::*;
   import ioRegPkg::*;

   wbDat_t aldWord;
   logic   access;

   // ALD word assembly
   always_comb begin
      aldWord = '0;
      aldWord[aldPrintLsb +: aldPrintW] = printNo;
      aldWord[aldStrapLsb +: aldStrapW] = strapBits;
      aldWord[aldCxBit]                 = cx;
      aldWord[aldFixLsb +: aldFixW]     = aldFixed;
      aldWord[aldSwLsb +: aldSwW]       = aldSwitch;
   end

   assign access = bus.cyc & bus.stb & ~bus.ack;

   always_ff @(posedge clk) begin
      if (!rstN) bus.ack <= 1'b0;
      else       bus.ack <= access;
   end

   // Read snapshot, INR for any slot other than ALD
   always_ff @(posedge clk) begin
      if (access && !bus.we) begin
         if (bus.adr == adrAld) bus.datR <= aldWord;
         else                   bus.datR <= wbDat_t'(inr);
      end
   end

endmodule

// ==== logic/ioRegTop.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// I/O register block, two Wishbone master ports, 2 cycle idle latency
// Board constants set here and passed to identRegs
//////////////////////////////////////////////////////////////////////
module ioRegTop #(
   parameter logic [ioRegPkg::aldPrintW-1:0] printNo   = 3'd5,   // 3202D
   parameter logic [ioRegPkg::aldStrapW-1:0] strapBits = 5'd0,
   parameter logic [ioRegPkg::aldSwW-1:0]    aldSwitch = 4'hF
) (
   input  logic                      clk,
   input  logic                      rstN,
   input  logic                      cpuCyc,
   input  logic                      cpuStb,
   input  logic                      cpuWe,
   input  wbBusPkg::wbAdr_t          cpuAdr,
   input  wbBusPkg::wbDat_t          cpuDatW,
   output wbBusPkg::wbDat_t          cpuDatR,
   output logic                      cpuAck,
   input  logic                      panelCyc,
   input  logic                      panelStb,
   input  logic                      panelWe,
   input  wbBusPkg::wbAdr_t          panelAdr,
   input  wbBusPkg::wbDat_t          panelDatW,
   output wbBusPkg::wbDat_t          panelDatR,
   output logic                      panelAck,
   input  logic [ioRegPkg::inrW-1:0] inr,
   input  logic                      cx,
   input  logic                      tbmt,
   input  logic                      dataAvail,
   output logic                      int10,
   output logic                      int12,
   output logic                      int13,
   output logic                      emcl,       // Red LED
   output logic                      ledGreen,
   output logic                      console
);

   wbIf cpuIf ();     // Master side links
   wbIf panelIf ();
   wbIf ctrlIf ();    // Slave side links
   wbIf identIf ();

   // CPU port
   assign cpuIf.cyc  = cpuCyc;
   assign cpuIf.stb  = cpuStb;
   assign cpuIf.we   = cpuWe;
   assign cpuIf.adr  = cpuAdr;
   assign cpuIf.datW = cpuDatW;
   assign cpuDatR    = cpuIf.datR;
   assign cpuAck     = cpuIf.ack;

   // Panel port
   assign panelIf.cyc  = panelCyc;
   assign panelIf.stb  = panelStb;
   assign panelIf.we   = panelWe;
   assign panelIf.adr  = panelAdr;
   assign panelIf.datW = panelDatW;
   assign panelDatR    = panelIf.datR;
   assign panelAck     = panelIf.ack;

   ioBusFabric i_ioBusFabric (
      .clk      (clk),
      .rstN     (rstN),
      .cpuBus   (cpuIf.slave),
      .panelBus (panelIf.slave),
      .ctrlBus  (ctrlIf.master),
      .identBus (identIf.master)
   );

   ioControlReg i_ioControlReg (
      .clk       (clk),
      .rstN      (rstN),
      .bus       (ctrlIf.slave),
      .tbmt      (tbmt),
      .dataAvail (dataAvail),
      .int10     (int10),
      .int12     (int12),
      .int13     (int13),
      .emcl      (emcl),
      .ledGreen  (ledGreen),
      .console   (console)
   );

   identRegs #(
      .printNo   (printNo),
      .strapBits (strapBits),
      .aldSwitch (aldSwitch)
   ) i_identRegs (
      .clk  (clk),
      .rstN (rstN),
      .bus  (identIf.slave),
      .inr  (inr),
      .cx   (cx)
   );

endmodule

// ==== test/ioReg_checker.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Handshake and grant assertions bound into every ioBusFabric
//////////////////////////////////////////////////////////////////////
module ioRegChecker (
   input logic                clk,
   input logic                rstN,
   input logic                busy,      // Fabric grant valid
   input wbBusPkg::masterId_t grant,
   input logic                cpuCyc,
   input logic                cpuStb,
   input logic                cpuAck,
   input logic                panelCyc,
   input logic                panelStb,
   input logic                panelAck
);
   import wbBusPkg::*;

   logic ownerCyc;                       // Owner cyc taken from the master ports

   assign ownerCyc = (grant == panelMaster) ? panelCyc : cpuCyc;

   // Ack is a single cycle pulse
   cpuAckPulse: assert property (@(posedge clk) disable iff (!rstN) cpuAck |=> !cpuAck)
      else $error("CPU ack high in two consecutive cycles");
   panelAckPulse: assert property (@(posedge clk) disable iff (!rstN) panelAck |=> !panelAck)
      else $error("Panel ack high in two consecutive cycles");

   // Ack only inside a live request
   cpuAckInCycle: assert property (@(posedge clk) disable iff (!rstN)
      cpuAck |-> cpuCyc && cpuStb)
      else $error("CPU ack without cyc and stb");
   panelAckInCycle: assert property (@(posedge clk) disable iff (!rstN)
      panelAck |-> panelCyc && panelStb)
      else $error("Panel ack without cyc and stb");

   // Owner keeps the bus while its cyc is up
   grantHeld: assert property (@(posedge clk) disable iff (!rstN)
      busy && ownerCyc |=> busy && $stable(grant))
      else $error("Grant moved while the owner held cyc");

endmodule

bind ioBusFabric ioRegChecker i_ioRegChecker (
   .clk      (clk),
   .rstN     (rstN),
   .busy     (busy),
   .grant    (grant),
   .cpuCyc   (cpuBus.cyc),
   .cpuStb   (cpuBus.stb),
   .cpuAck   (cpuBus.ack),
   .panelCyc (panelBus.cyc),
   .panelStb (panelBus.stb),
   .panelAck (panelBus.ack)
);

// ==== test/ioRegTb.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Random register test of ioRegTop with the default board constants
// Inputs driven and outputs sampled on the falling edge
//////////////////////////////////////////////////////////////////////
module ioRegTb;
   import wbBusPkg::*;

   localparam logic [2:0] printNo   = 3'd5;   // Same as DUT defaults
   localparam logic [4:0] strapBits = 5'd0;
   localparam logic [3:0] aldSwitch = 4'hF;
   localparam wbAdr_t     slotIoc   = 2'd0;
   localparam wbAdr_t     slotInr   = 2'd1;
   localparam wbAdr_t     slotAld   = 2'd2;
   localparam wbAdr_t     slotNone  = 2'd3;   // Unmapped
   localparam int         ackLimit  = 20;     // Cycles per access

   logic        clk;
   logic        rstN;
   logic        cpuCyc, cpuStb, cpuWe, cpuAck;
   wbAdr_t      cpuAdr;
   wbDat_t      cpuDatW, cpuDatR;
   logic        panelCyc, panelStb, panelWe, panelAck;
   wbAdr_t      panelAdr;
   wbDat_t      panelDatW, panelDatR;
   logic [7:0]  inr;
   logic        cx, tbmt, dataAvail;
   logic        int10, int12, int13, emcl, ledGreen, console;
   logic [31:0] lcgState;
   logic [7:0]  iocModel;                     // Last IOC byte written

   ioRegTop #(
      .printNo   (printNo),
      .strapBits (strapBits),
      .aldSwitch (aldSwitch)
   ) i_ioRegTop (.*);

   always #10 clk = ~clk;                     // 20 ns period

   function automatic logic [15:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[31:16];                 // High half has the longer period
   endfunction

   function automatic masterId_t pickMaster();
      logic [15:0] r;
      r = nextRand();
      if (r[8]) return panelMaster;
      return cpuMaster;
   endfunction

   // ALD word as print, strap, cx, 0, 11, switch from msb down
   function automatic wbDat_t aldExpect(input logic cxNow);
      return {printNo, strapBits, cxNow, 1'b0, 2'b11, aldSwitch};
   endfunction

   task automatic abortRun();
      $display("Test failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkDat(input string name, input wbDat_t exp, input wbDat_t act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         abortRun();
      end
   endtask

   task automatic checkLine(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         abortRun();
      end
   endtask

   task automatic checkCycles(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
         abortRun();
      end
   endtask

   // Bit rules of the IOC outputs
   task automatic checkOutputs();
      checkLine("console", iocModel[0], console);
      checkLine("emcl", iocModel[1], emcl);
      checkLine("ledGreen", iocModel[2], ledGreen);
      checkLine("int10", iocModel[4] & tbmt, int10);
      checkLine("int12", iocModel[5] & iocModel[6] & dataAvail, int12);
      checkLine("int13", iocModel[3] & iocModel[7], int13);
   endtask

   task automatic driveReq(input masterId_t who, input logic req, input logic we,
                           input wbAdr_t adr, input wbDat_t dat);
      if (who == cpuMaster) begin
         cpuCyc  = req;
         cpuStb  = req;
         cpuWe   = we;
         cpuAdr  = adr;
         cpuDatW = dat;
      end else begin
         panelCyc  = req;
         panelStb  = req;
         panelWe   = we;
         panelAdr  = adr;
         panelDatW = dat;
      end
   endtask

   // One Wishbone access where lat counts falling edges until ack is seen
   task automatic busAccess(input masterId_t who, input logic we, input wbAdr_t adr,
                            input wbDat_t datW, output wbDat_t datR, output int lat);
      logic ack;
      ack = 1'b0;
      lat = 0;
      @(negedge clk);
      driveReq(who, 1'b1, we, adr, datW);
      while (!ack) begin
         @(negedge clk);
         lat++;
         ack = (who == cpuMaster) ? cpuAck : panelAck;
         if (!ack && lat >= ackLimit) begin
            $display("No ack for the %s master within %0d cycles", who.name(), ackLimit);
            abortRun();
         end
      end
      datR = (who == cpuMaster) ? cpuDatR : panelDatR;
      @(negedge clk);                        // Ack sampled at the edge between
      driveReq(who, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic readCheck(input masterId_t who, input wbAdr_t adr, input string name,
                            input wbDat_t exp);
      wbDat_t rd;
      int     lat;
      busAccess(who, 1'b0, adr, '0, rd, lat);
      checkDat(name, exp, rd);
   endtask

   initial begin
      wbDat_t      wDat;
      wbDat_t      rDat;
      wbDat_t      pDat;
      int          lat;
      int          pLat;
      logic [15:0] r;
      clk       = 1'b0;
      rstN      = 1'b0;
      inr       = '0;
      cx        = 1'b0;
      tbmt      = 1'b0;
      dataAvail = 1'b0;
      lcgState  = 32'd68535;
      iocModel  = '0;
      driveReq(cpuMaster, 1'b0, 1'b0, '0, '0);
      driveReq(panelMaster, 1'b0, 1'b0, '0, '0);
      repeat (8) @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);

      // Quiet after reset
      checkLine("cpuAck", 1'b0, cpuAck);
      checkLine("panelAck", 1'b0, panelAck);
      checkOutputs();                        // Model is zero here
      readCheck(cpuMaster, slotIoc, "ioc after reset", '0);

      repeat (10) begin                      // Idle bus latency
         busAccess(pickMaster(), 1'b0, slotIoc, '0, rDat, lat);
         checkCycles("ack latency", 2, lat);
      end

      repeat (200) begin
         wDat = nextRand();
         busAccess(pickMaster(), 1'b1, slotIoc, wDat, rDat, lat);
         iocModel = wDat[7:0];               // High byte dropped
         checkOutputs();                     // Cycle after ack
         r = nextRand();
         tbmt      = r[3];
         dataAvail = r[11];
         @(negedge clk);
         checkOutputs();
         readCheck(pickMaster(), slotIoc, "ioc readback", {8'h00, iocModel});
      end

      repeat (20) begin
         r = nextRand();
         @(negedge clk);
         inr = r[7:0];
         cx  = r[12];
         readCheck(pickMaster(), slotInr, "inr", {8'h00, inr});
         readCheck(pickMaster(), slotAld, "ald", aldExpect(cx));
      end

      // Same edge requests with CPU priority
      repeat (10) begin
         wDat = nextRand();
         fork
            busAccess(cpuMaster, 1'b1, slotIoc, wDat, rDat, lat);
            busAccess(panelMaster, 1'b0, slotIoc, '0, pDat, pLat);
         join
         iocModel = wDat[7:0];
         checkCycles("cpu latency under contention", 2, lat);
         if (pLat <= lat) begin
            $display("Panel access was not served after the CPU access");
            abortRun();
         end
         checkDat("panel read after cpu write", {8'h00, iocModel}, pDat);
      end

      repeat (10) begin                      // Writes that must be dropped
         r = nextRand();
         @(negedge clk);
         inr = r[7:0];
         cx  = r[15];
         busAccess(pickMaster(), 1'b1, slotInr, nextRand(), rDat, lat);
         busAccess(pickMaster(), 1'b1, slotAld, nextRand(), rDat, lat);
         readCheck(pickMaster(), slotInr, "inr after write", {8'h00, inr});
         readCheck(pickMaster(), slotAld, "ald after write", aldExpect(cx));
         readCheck(pickMaster(), slotIoc, "ioc after ident writes", {8'h00, iocModel});
         busAccess(pickMaster(), 1'b1, slotNone, nextRand(), rDat, lat);
         readCheck(pickMaster(), slotNone, "unmapped slot", '0);
         readCheck(pickMaster(), slotIoc, "ioc after unmapped write", {8'h00, iocModel});
      end

      $display("Test passed");
      $finish;
   end

endmodule

// ==== list.f ====
logic/wbBusPkg.sv
logic/ioRegPkg.sv
logic/wbIf.sv
logic/ioBusFabric.sv
logic/ioControlReg.sv
logic/identRegs.sv
logic/ioRegTop.sv
test/ioReg_checker.sv
test/ioRegTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run ioRegTb with Verilator, verdict taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ioRegTb -f list.f -o simIoReg \
   && ./obj_dir/simIoReg > sim.log 2>&1 \
   || echo "Test failed" >> sim.log
cat sim.log
if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0
